/* hw/adc_lane_pkg.sv */
package adc_lane_pkg;

    localparam int num_lanes = 4;

    typedef logic [1:0]  lane_id_t;
    typedef logic [15:0] lane_word_t;
    typedef logic [15:0] err_count_t;
    typedef logic [3:0]  axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  slide_off_t;

    localparam lane_word_t train_pattern = 16'hA5C3;
    localparam int lock_run = 8;
    localparam int run_w = $clog2(lock_run + 1);

    typedef logic [run_w-1:0] run_count_t;

    // Register map
    localparam axi_addr_t reg_sel    = 4'h0;
    localparam axi_addr_t reg_ctrl   = 4'h4;
    localparam axi_addr_t reg_cmd    = 4'h8;
    localparam axi_addr_t reg_status = 4'hC;

    // Field order follows the register bit layout, LSB last
    typedef struct packed {
        logic       hold;
        logic       match_en;
        logic [1:0] nib_sel;
        logic       invert;
    } lane_ctrl_t;

    typedef struct packed {
        logic err_clear;
        logic slide;
    } lane_cmd_t;

    typedef struct packed {
        logic       locked;
        err_count_t err_count;
    } lane_stat_t;

    typedef lane_word_t [num_lanes-1:0] lane_words_t;

endpackage

/* hw/lane_ctrl_regs.sv */
module lane_ctrl_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     awvalid,
    output logic                     awready,
    input  adc_lane_pkg::axi_addr_t  awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  adc_lane_pkg::axi_data_t  wdata,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic                     arvalid,
    output logic                     arready,
    input  adc_lane_pkg::axi_addr_t  araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output adc_lane_pkg::axi_data_t  rdata,
    output adc_lane_pkg::lane_id_t   sel,
    output adc_lane_pkg::lane_ctrl_t ctrl,
    output adc_lane_pkg::lane_cmd_t  cmd,
    input  adc_lane_pkg::lane_stat_t status
);
    import adc_lane_pkg::*;

    logic      aw_hs;
    logic      ar_hs;
    axi_data_t read_mux;

    assign aw_hs = awready & awvalid & wready & wvalid;
    assign ar_hs = arready & arvalid;

    //////////////////////////////////////////////////////////////////////
    // Write channel and registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            sel     <= '0;
            ctrl    <= '0;
            cmd     <= '0;
        end
        else
        begin
            // Command bits live for one cycle only
            cmd     <= '0;
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;

            if (bvalid && bready)
                bvalid <= 1'b0;

            if (aw_hs)
            begin
                bvalid <= 1'b1;
                case (awaddr)
                    reg_sel:  sel  <= wdata[1:0];
                    reg_ctrl: ctrl <= lane_ctrl_t'(wdata[4:0]);
                    reg_cmd:  cmd  <= lane_cmd_t'(wdata[1:0]);
                    default:  ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        read_mux = '0;
        case (araddr)
            reg_sel:    read_mux = {30'b0, sel};
            reg_ctrl:   read_mux = {27'b0, ctrl};
            reg_status: read_mux = {15'b0, status};
            default:    read_mux = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            arready <= arvalid && !rvalid && !arready;
            if (ar_hs)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // Snapshot taken on the address handshake
    always_ff @(posedge clk)
    begin
        if (ar_hs)
            rdata <= read_mux;
    end

    a_bvalid_after_write: assert property (
        @(posedge clk) disable iff (rst)
        $rose(bvalid) |-> $past(aw_hs)
    ) else $error("bvalid raised without a write handshake");

endmodule

/* hw/lane_select.sv */
module lane_select (
    input  logic                     clk,
    input  logic                     rst,
    input  adc_lane_pkg::lane_id_t   sel,
    input  adc_lane_pkg::lane_ctrl_t ctrl,
    input  adc_lane_pkg::lane_cmd_t  cmd,
    input  adc_lane_pkg::lane_stat_t [adc_lane_pkg::num_lanes-1:0] lane_stat,
    output adc_lane_pkg::lane_ctrl_t [adc_lane_pkg::num_lanes-1:0] lane_ctrl,
    output adc_lane_pkg::lane_cmd_t  [adc_lane_pkg::num_lanes-1:0] lane_cmd,
    output adc_lane_pkg::lane_stat_t status
);
    import adc_lane_pkg::*;

    logic [num_lanes-1:0] cmd_hit;

    // Only the selected lane follows ctrl, the rest keep their last value
    always_ff @(posedge clk)
    begin
        if (rst)
            lane_ctrl <= '0;
        else
            lane_ctrl[sel] <= ctrl;
    end

    always_comb
    begin
        for (int i = 0; i < num_lanes; i++)
        begin
            lane_cmd[i] = (sel == lane_id_t'(i)) ? cmd : '0;
            cmd_hit[i]  = |lane_cmd[i];
        end
    end

    assign status = lane_stat[sel];

    a_one_lane_cmd: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(cmd_hit)
    ) else $error("command pulse reached more than one lane");

endmodule

/* hw/lane_monitor.sv */
module lane_monitor (
    input  logic                     clk,
    input  logic                     rst,
    input  adc_lane_pkg::lane_word_t word,
    input  adc_lane_pkg::lane_ctrl_t ctrl,
    input  adc_lane_pkg::lane_cmd_t  cmd,
    output adc_lane_pkg::lane_stat_t stat
);
    import adc_lane_pkg::*;

    slide_off_t  slide_off;
    lane_word_t  inv_word;
    lane_word_t  aligned;
    logic [3:0]  rot;
    logic [31:0] doubled;
    logic        match;
    run_count_t  run;
    logic        locked;
    err_count_t  err_count;

    //////////////////////////////////////////////////////////////////////
    // Alignment
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
            slide_off <= '0;
        else if (cmd.slide)
            slide_off <= slide_off + 4'd1;
    end

    always_comb
    begin
        inv_word = ctrl.invert ? ~word : word;
        // Nibble step plus bit slides, wraps mod 16
        rot      = {ctrl.nib_sel, 2'b00} + slide_off;
        doubled  = {inv_word, inv_word} << rot;
        aligned  = doubled[31:16];
        match    = (aligned == train_pattern);
    end

    //////////////////////////////////////////////////////////////////////
    // Lock and error tracking
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            run       <= '0;
            locked    <= 1'b0;
            err_count <= '0;
        end
        else
        begin
            if (!ctrl.hold)
            begin
                if (!ctrl.match_en)
                begin
                    run    <= '0;
                    locked <= 1'b0;
                end
                else if (match)
                begin
                    if (run != run_count_t'(lock_run))
                        run <= run + 1'b1;
                    if (run >= run_count_t'(lock_run - 1))
                        locked <= 1'b1;
                end
                else
                begin
                    run    <= '0;
                    locked <= 1'b0;
                    if (err_count != '1)
                        err_count <= err_count + 1'b1;
                end
            end

            // Clear wins over a same-cycle mismatch
            if (cmd.err_clear)
                err_count <= '0;
        end
    end

    assign stat.locked    = locked;
    assign stat.err_count = err_count;

endmodule

/* hw/adc_lane_top.sv */
module adc_lane_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      awvalid,
    output logic                      awready,
    input  adc_lane_pkg::axi_addr_t   awaddr,
    input  logic                      wvalid,
    output logic                      wready,
    input  adc_lane_pkg::axi_data_t   wdata,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic                      arvalid,
    output logic                      arready,
    input  adc_lane_pkg::axi_addr_t   araddr,
    output logic                      rvalid,
    input  logic                      rready,
    output adc_lane_pkg::axi_data_t   rdata,
    input  adc_lane_pkg::lane_words_t lane_words
);
    import adc_lane_pkg::*;

    lane_id_t                   sel;
    lane_ctrl_t                 ctrl;
    lane_cmd_t                  cmd;
    lane_stat_t                 status;
    lane_ctrl_t [num_lanes-1:0] lane_ctrl;
    lane_cmd_t  [num_lanes-1:0] lane_cmd;
    lane_stat_t [num_lanes-1:0] lane_stat;

    lane_ctrl_regs regs_i (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .sel     (sel),
        .ctrl    (ctrl),
        .cmd     (cmd),
        .status  (status)
    );

    lane_select select_i (
        .clk       (clk),
        .rst       (rst),
        .sel       (sel),
        .ctrl      (ctrl),
        .cmd       (cmd),
        .lane_stat (lane_stat),
        .lane_ctrl (lane_ctrl),
        .lane_cmd  (lane_cmd),
        .status    (status)
    );

    for (genvar i = 0; i < num_lanes; i++)
    begin : g_lane
        lane_monitor monitor_i (
            .clk  (clk),
            .rst  (rst),
            .word (lane_words[i]),
            .ctrl (lane_ctrl[i]),
            .cmd  (lane_cmd[i]),
            .stat (lane_stat[i])
        );
    end

endmodule

/* test/lane_checker.sv */
module lane_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      awvalid,
    input  logic                      awready,
    input  adc_lane_pkg::axi_addr_t   awaddr,
    input  logic                      wvalid,
    input  logic                      wready,
    input  adc_lane_pkg::axi_data_t   wdata,
    input  logic                      arvalid,
    input  logic                      arready,
    input  adc_lane_pkg::axi_addr_t   araddr,
    input  logic                      rvalid,
    input  logic                      rready,
    input  adc_lane_pkg::axi_data_t   rdata,
    input  adc_lane_pkg::lane_words_t lane_words,
    output int                        checks,
    output int                        errors
);
    timeunit 1ns;
    timeprecision 100ps;
    import adc_lane_pkg::*;

    lane_id_t   sel_m;
    lane_ctrl_t ctrl_m;
    lane_cmd_t  cmd_m;
    lane_ctrl_t held_m [num_lanes];
    slide_off_t off_m [num_lanes];
    int         run_m [num_lanes];
    logic       lock_m [num_lanes];
    err_count_t err_m [num_lanes];
    axi_data_t  exp_rdata;
    logic       exp_pending;

    // Invert, then rotate left one bit at a time
    function automatic logic pattern_hit(lane_word_t w, lane_ctrl_t c, slide_off_t off);
        lane_word_t v;
        int         n;
        v = c.invert ? ~w : w;
        n = (4 * c.nib_sel + off) % 16;
        for (int k = 0; k < n; k++)
            v = {v[14:0], v[15]};
        return v == train_pattern;
    endfunction

    always @(posedge clk)
    begin
        lane_cmd_t c;
        logic      hit;
        if (rst)
        begin
            sel_m       <= '0;
            ctrl_m      <= '0;
            cmd_m       <= '0;
            exp_pending <= 1'b0;
            checks      <= 0;
            errors      <= 0;
            for (int l = 0; l < num_lanes; l++)
            begin
                held_m[l] <= '0;
                off_m[l]  <= '0;
                run_m[l]  <= 0;
                lock_m[l] <= 1'b0;
                err_m[l]  <= '0;
            end
        end
        else
        begin
            //////////////////////////////////////////////////////////////////////
            // Register block and selector
            //////////////////////////////////////////////////////////////////////
            cmd_m <= '0;
            if (awvalid && awready && wvalid && wready)
            begin
                case (awaddr)
                    reg_sel:  sel_m  <= wdata[1:0];
                    reg_ctrl: ctrl_m <= lane_ctrl_t'(wdata[4:0]);
                    reg_cmd:  cmd_m  <= lane_cmd_t'(wdata[1:0]);
                    default:  ;
                endcase
            end
            held_m[sel_m] <= ctrl_m;

            //////////////////////////////////////////////////////////////////////
            // Lane models
            //////////////////////////////////////////////////////////////////////
            for (int l = 0; l < num_lanes; l++)
            begin
                c = '0;
                if (sel_m == lane_id_t'(l))
                    c = cmd_m;
                hit = pattern_hit(lane_words[l], held_m[l], off_m[l]);
                if (c.slide)
                    off_m[l] <= off_m[l] + 1'b1;
                if (!held_m[l].hold)
                begin
                    if (!held_m[l].match_en || !hit)
                    begin
                        run_m[l]  <= 0;
                        lock_m[l] <= 1'b0;
                    end
                    else
                    begin
                        run_m[l] <= run_m[l] + 1;
                        if (run_m[l] + 1 >= lock_run)
                            lock_m[l] <= 1'b1;
                    end
                    if (held_m[l].match_en && !hit && err_m[l] != '1)
                        err_m[l] <= err_m[l] + 1'b1;
                end
                if (c.err_clear)
                    err_m[l] <= '0;
            end

            // Compare a status response with the lane selected at its address
            if (rvalid && rready && exp_pending)
            begin
                exp_pending <= 1'b0;
                checks      <= checks + 1;
                if (rdata !== exp_rdata)
                begin
                    errors <= errors + 1;
                    $display("error at %0t: rdata expected %h, actual %h",
                             $time, exp_rdata, rdata);
                end
            end
            if (arvalid && arready)
            begin
                exp_pending <= (araddr == reg_status);
                exp_rdata   <= {15'b0, lock_m[sel_m], err_m[sel_m]};
            end
        end
    end

endmodule

/* test/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import adc_lane_pkg::*;

    localparam int wait_limit = 40;

    logic        clk;
    logic        rst;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    axi_addr_t   awaddr;
    axi_addr_t   araddr;
    axi_data_t   wdata;
    axi_data_t   rdata;
    lane_words_t lane_words;
    logic        use_pattern [num_lanes];
    lane_word_t  pattern_word [num_lanes];
    int          checks;
    int          errors;
    int          timeouts;

    adc_lane_top dut_i (.*);
    lane_checker checker_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Fresh lane words every cycle
    always @(posedge clk)
    begin
        #1;
        for (int l = 0; l < num_lanes; l++)
            lane_words[l] = use_pattern[l] ? pattern_word[l] : lane_word_t'($urandom);
    end

    // Word that lands on the pattern after inversion and a left rotation
    function automatic lane_word_t pre_align(logic inv, int rot);
        lane_word_t v;
        v = train_pattern;
        for (int k = 0; k < rot; k++)
            v = {v[0], v[15:1]};
        return inv ? ~v : v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_timeout(string what);
        $display("Timeout at %0t waiting for %s", $time, what);
        timeouts++;
    endtask

    task automatic axi_write(axi_addr_t addr, axi_data_t data);
        int n;
        next_cycle();
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do
        begin
            next_cycle();
            n++;
        end
        while (!(awready && wready) && n < wait_limit);
        if (!(awready && wready))
            report_timeout("the write address and data handshake");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < wait_limit)
        begin
            next_cycle();
            n++;
        end
        if (!bvalid)
            report_timeout("the write response");
        next_cycle();
    endtask

    task automatic axi_read(axi_addr_t addr);
        int n;
        next_cycle();
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do
        begin
            next_cycle();
            n++;
        end
        while (!arready && n < wait_limit);
        if (!arready)
            report_timeout("the read address handshake");
        next_cycle();
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < wait_limit)
        begin
            next_cycle();
            n++;
        end
        if (!rvalid)
            report_timeout("the read data");
        next_cycle();
    endtask

    task automatic read_lane(int lane);
        axi_write(reg_sel, axi_data_t'(lane));
        axi_read(reg_status);
    endtask

    initial
    begin
        void'($urandom(32'hd01f));
        rst        = 1'b1;
        {awvalid, wvalid, arvalid} = 3'b000;
        bready     = 1'b1;
        rready     = 1'b1;
        awaddr     = '0;
        araddr     = '0;
        wdata      = '0;
        lane_words = '0;
        timeouts   = 0;
        for (int l = 0; l < num_lanes; l++)
        begin
            use_pattern[l]  = 1'b0;
            pattern_word[l] = '0;
        end
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;

        for (int l = 0; l < num_lanes; l++)
            read_lane(l);

        // Lane 1 locks with invert and nib_sel 2
        pattern_word[1] = pre_align(1'b1, 8);
        use_pattern[1]  = 1'b1;
        axi_write(reg_sel, 1);
        axi_write(reg_ctrl, 32'h0D);
        repeat (lock_run + 4) @(posedge clk);
        axi_read(reg_status);
        read_lane(0);
        axi_write(reg_ctrl, 32'h00);

        // Random words on lane 3, then clear its count only
        axi_write(reg_sel, 3);
        axi_write(reg_ctrl, 32'h08);
        repeat (20) @(posedge clk);
        axi_read(reg_status);
        axi_write(reg_ctrl, 32'h00);
        axi_write(reg_cmd, 32'h2);
        axi_read(reg_status);
        read_lane(0);

        // Lane 0 needs three slides
        pattern_word[0] = pre_align(1'b0, 3);
        use_pattern[0]  = 1'b1;
        axi_write(reg_ctrl, 32'h08);
        repeat (3)
        begin
            axi_write(reg_cmd, 32'h1);
            repeat (lock_run + 2) @(posedge clk);
            axi_read(reg_status);
        end

        // Lane 2 keeps its setup while lane 0 is reconfigured
        pattern_word[2] = pre_align(1'b1, 4);
        use_pattern[2]  = 1'b1;
        axi_write(reg_sel, 2);
        axi_write(reg_ctrl, 32'h0B);
        repeat (lock_run + 4) @(posedge clk);
        axi_read(reg_status);
        axi_write(reg_sel, 0);
        axi_write(reg_ctrl, 32'h08);
        repeat (lock_run + 4) @(posedge clk);
        axi_read(reg_status);
        axi_write(reg_ctrl, 32'h18);
        axi_write(reg_sel, 2);
        axi_read(reg_status);

        // Hold freezes lane 1 under random words
        axi_write(reg_sel, 1);
        use_pattern[1] = 1'b0;
        repeat (20) @(posedge clk);
        axi_read(reg_status);
        axi_write(reg_ctrl, 32'h0D);
        repeat (10) @(posedge clk);
        axi_read(reg_status);

        repeat (5) @(posedge clk);
        $display("Status reads %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* list.f */
hw/adc_lane_pkg.sv
hw/lane_ctrl_regs.sv
hw/lane_select.sv
hw/lane_monitor.sv
hw/adc_lane_top.sv
test/lane_checker.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
# Build tb_top with Verilator, run it, and judge the log
verilator --binary --timing --assert --top-module tb_top -f list.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "No errors" sim.log || { echo "No verdict in the log"; exit 1; }
echo "PASS"
